// File: mem_stage_consts.svh
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// MIPS primary opcodes, instr[31:26]
`define OP_LB   6'b100000
`define OP_LH   6'b100001
`define OP_LWL  6'b100010
`define OP_LW   6'b100011
`define OP_LBU  6'b100100
`define OP_LHU  6'b100101
`define OP_LWR  6'b100110

`define OP_SB   6'b101000
`define OP_SH   6'b101001
`define OP_SWL  6'b101010
`define OP_SW   6'b101011
`define OP_SWR  6'b101110

`define OP_LL   6'b110000  // no link tracking here
`define OP_SC   6'b111000  // behaves as sw

// datapath
`define DATA_W  32

// word address into the data RAM, 256 words
`define RAM_AW  8

`endif

// File: rtl/mem_pkg.sv
`include "mem_stage_consts.svh"

package mem_pkg;

    // one RAM word, read either as byte lanes or as halfword lanes
    typedef union packed {
        logic [`DATA_W/8-1:0][7:0]   bytes;   // lane 0 = bits 7:0
        logic [`DATA_W/16-1:0][15:0] halves;  // lane 0 = bits 15:0
    } memWord_u;

endpackage

// File: rtl/mem_access_unit.sv
`timescale 1ns/100ps
`include "mem_stage_consts.svh"

module mem_access_unit
    import mem_pkg::*;
(
    input  logic [31:0]        instr,
    input  logic [31:0]        addr,
    input  logic [31:0]        wdata,
    input  logic [31:0]        rtValue,
    output logic               memReq,
    output logic               storeErr,
    output logic               loadErr,
    output logic [`RAM_AW-1:0] reqAddr,
    output logic [3:0]         reqByteEn,
    output logic [31:0]        reqWdata,
    output logic [5:0]         reqOpcode,
    output logic [1:0]         reqOffset,
    output logic [31:0]        reqRtValue
);

    logic [5:0] opcode;
    logic [1:0] offset;
    logic       isMemOp;
    logic [3:0] byteEn;
    memWord_u   laneData;

    assign opcode = instr[31:26];
    assign offset = addr[1:0];

    always_comb begin
        isMemOp  = 1'b1;
        byteEn   = 4'b0000;
        laneData = wdata;
        storeErr = 1'b0;
        loadErr  = 1'b0;
        case (opcode)
            `OP_SW, `OP_SC: begin
                byteEn   = 4'b1111;
                storeErr = (offset != 2'b00);
            end
            `OP_SH: begin
                byteEn          = offset[1] ? 4'b1100 : 4'b0011;
                laneData.halves = {2{wdata[15:0]}};  // same half in both lanes
                storeErr        = offset[0];
            end
            `OP_SB: begin
                byteEn         = 4'b0001 << offset;
                laneData.bytes = {4{wdata[7:0]}};
            end
            `OP_SWL: begin
                // bytes offset..0 get the top of rt
                byteEn   = 4'b1111 >> (~offset);
                laneData = wdata >> {~offset, 3'b000};
            end
            `OP_SWR: begin
                byteEn   = 4'b1111 << offset;
                laneData = wdata << {offset, 3'b000};
            end
            `OP_LW, `OP_LL: begin
                loadErr = (offset != 2'b00);
            end
            `OP_LH, `OP_LHU: begin
                loadErr = offset[0];
            end
            `OP_LB, `OP_LBU, `OP_LWL, `OP_LWR: begin
                loadErr = 1'b0;  // any offset is legal
            end
            default: begin
                isMemOp = 1'b0;
            end
        endcase
    end

    // misaligned ops never reach the RAM
    assign memReq     = isMemOp & ~storeErr & ~loadErr;
    assign reqByteEn  = memReq ? byteEn : 4'b0000;
    assign reqAddr    = addr[`RAM_AW+1:2];
    assign reqWdata   = laneData;
    assign reqOpcode  = opcode;
    assign reqOffset  = offset;
    assign reqRtValue = rtValue;  // lwl/lwr merge source

endmodule

// File: rtl/mem_port_arbiter.sv
`timescale 1ns/100ps
`include "mem_stage_consts.svh"

module mem_port_arbiter
    import mem_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               memReq1,
    input  logic               memReq2,
    input  logic [`RAM_AW-1:0] reqAddr1,
    input  logic [`RAM_AW-1:0] reqAddr2,
    input  logic [3:0]         reqByteEn1,
    input  logic [3:0]         reqByteEn2,
    input  logic [31:0]        reqWdata1,
    input  logic [31:0]        reqWdata2,
    input  logic [5:0]         reqOpcode1,
    input  logic [5:0]         reqOpcode2,
    input  logic [1:0]         reqOffset1,
    input  logic [1:0]         reqOffset2,
    input  logic [31:0]        reqRtValue1,
    input  logic [31:0]        reqRtValue2,
    output logic               stall,
    output logic [3:0]         ramWe,
    output logic [`RAM_AW-1:0] ramAddr,
    output memWord_u           ramWdata,
    output logic               grantLoad,
    output logic               grantSlot,
    output logic [5:0]         grantOpcode,
    output logic [1:0]         grantOffset,
    output logic [31:0]        grantRtValue
);

    logic       pending2;  // slot 2 still owed a turn
    logic       grant1;
    logic       grant2;
    logic       grantAny;
    logic [3:0] selByteEn;

    // slot 1 is older, it always goes first
    assign stall    = memReq1 & memReq2 & ~pending2;
    assign grant1   = memReq1 & ~pending2;
    assign grant2   = memReq2 & (pending2 | ~memReq1);
    assign grantAny = grant1 | grant2;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending2 <= 1'b0;
        end else begin
            pending2 <= stall;  // one cycle only
        end
    end

    assign selByteEn = grant2 ? reqByteEn2 : reqByteEn1;

    assign ramWe    = grantAny ? selByteEn : 4'b0000;
    assign ramAddr  = grant2 ? reqAddr2 : reqAddr1;
    assign ramWdata = grant2 ? reqWdata2 : reqWdata1;

    assign grantLoad    = grantAny & (selByteEn == 4'b0000);  // no lanes means load
    assign grantSlot    = grant2;  // high for slot 2
    assign grantOpcode  = grant2 ? reqOpcode2 : reqOpcode1;
    assign grantOffset  = grant2 ? reqOffset2 : reqOffset1;
    assign grantRtValue = grant2 ? reqRtValue2 : reqRtValue1;

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/100ps
`include "mem_stage_consts.svh"

module data_ram (
    input  logic                clk,
    input  logic [3:0]          we,
    input  logic [`RAM_AW-1:0]  addr,
    input  logic [`DATA_W-1:0]  wdata,
    output logic [`DATA_W-1:0]  rdata
);

    logic [`DATA_W-1:0] mem [0:(1<<`RAM_AW)-1];

    // byte lane writes
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we[lane]) begin
                mem[addr][8*lane +: 8] <= wdata[8*lane +: 8];
            end
        end
    end

    // registered read, old word on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// File: rtl/load_align.sv
`timescale 1ns/100ps
`include "mem_stage_consts.svh"

module load_align
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        grantLoad,
    input  logic        grantSlot,
    input  logic [5:0]  grantOpcode,
    input  logic [1:0]  grantOffset,
    input  logic [31:0] grantRtValue,
    input  memWord_u    ramRdata,
    output logic        loadValid,
    output logic        loadSlot,
    output logic [31:0] loadData
);

    logic        validM2;
    logic        slotM2;
    logic [5:0]  opM2;
    logic [1:0]  offM2;
    logic [31:0] rtM2;
    logic [7:0]  laneByte;
    logic [15:0] laneHalf;
    logic [4:0]  lwlShift;
    logic [4:0]  lwrShift;

    // M2 register
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            validM2 <= 1'b0;
        end else begin
            validM2 <= grantLoad;
        end
    end

    always_ff @(posedge clk) begin
        slotM2 <= grantSlot;
        opM2   <= grantOpcode;
        offM2  <= grantOffset;
        rtM2   <= grantRtValue;
    end

    assign laneByte = ramRdata.bytes[offM2];
    assign laneHalf = ramRdata.halves[offM2[1]];
    assign lwlShift = {~offM2, 3'b000};  // 8*(3-offset)
    assign lwrShift = {offM2, 3'b000};

    always_comb begin
        case (opM2)
            `OP_LW, `OP_LL: begin
                loadData = ramRdata;
            end
            `OP_LH: begin
                loadData = {{16{laneHalf[15]}}, laneHalf};
            end
            `OP_LHU: begin
                loadData = {16'h0000, laneHalf};
            end
            `OP_LB: begin
                loadData = {{24{laneByte[7]}}, laneByte};
            end
            `OP_LBU: begin
                loadData = {24'h000000, laneByte};
            end
            `OP_LWL: begin
                // memory fills the top, rt keeps the low bytes
                loadData = (ramRdata << lwlShift) | (rtM2 & ~(32'hffff_ffff << lwlShift));
            end
            `OP_LWR: begin
                loadData = (ramRdata >> lwrShift) | (rtM2 & ~(32'hffff_ffff >> lwrShift));
            end
            default: begin
                loadData = 32'h0000_0000;
            end
        endcase
    end

    // a flush also kills the load sitting in M2 right now
    assign loadValid = validM2 & ~flush;
    assign loadSlot  = slotM2;

endmodule

// File: rtl/mem_stage.sv
`timescale 1ns/100ps
`include "mem_stage_consts.svh"

module mem_stage
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic [31:0] instr1,
    input  logic [31:0] instr2,
    input  logic [31:0] addr1,
    input  logic [31:0] addr2,
    input  logic [31:0] wdata1,
    input  logic [31:0] wdata2,
    input  logic [31:0] rtValue1,
    input  logic [31:0] rtValue2,
    output logic        stall,
    output logic        loadValid,
    output logic        loadSlot,
    output logic [31:0] loadData,
    output logic        storeErr1,
    output logic        loadErr1,
    output logic        storeErr2,
    output logic        loadErr2
);

    logic               memReq1, memReq2;
    logic [`RAM_AW-1:0] reqAddr1, reqAddr2;
    logic [3:0]         reqByteEn1, reqByteEn2;
    logic [31:0]        reqWdata1, reqWdata2;
    logic [5:0]         reqOpcode1, reqOpcode2;
    logic [1:0]         reqOffset1, reqOffset2;
    logic [31:0]        reqRtValue1, reqRtValue2;

    logic [3:0]         ramWe;
    logic [`RAM_AW-1:0] ramAddr;
    memWord_u           ramWdata;
    memWord_u           ramRdata;

    logic               grantLoad;
    logic               grantSlot;
    logic [5:0]         grantOpcode;
    logic [1:0]         grantOffset;
    logic [31:0]        grantRtValue;

    mem_access_unit slot1Unit (
        .instr(instr1), .addr(addr1), .wdata(wdata1), .rtValue(rtValue1),
        .memReq(memReq1), .storeErr(storeErr1), .loadErr(loadErr1),
        .reqAddr(reqAddr1), .reqByteEn(reqByteEn1), .reqWdata(reqWdata1),
        .reqOpcode(reqOpcode1), .reqOffset(reqOffset1), .reqRtValue(reqRtValue1)
    );

    mem_access_unit slot2Unit (
        .instr(instr2), .addr(addr2), .wdata(wdata2), .rtValue(rtValue2),
        .memReq(memReq2), .storeErr(storeErr2), .loadErr(loadErr2),
        .reqAddr(reqAddr2), .reqByteEn(reqByteEn2), .reqWdata(reqWdata2),
        .reqOpcode(reqOpcode2), .reqOffset(reqOffset2), .reqRtValue(reqRtValue2)
    );

    mem_port_arbiter portArb (
        .clk(clk), .rst(rst), .memReq1(memReq1), .memReq2(memReq2),
        .reqAddr1(reqAddr1), .reqAddr2(reqAddr2),
        .reqByteEn1(reqByteEn1), .reqByteEn2(reqByteEn2),
        .reqWdata1(reqWdata1), .reqWdata2(reqWdata2),
        .reqOpcode1(reqOpcode1), .reqOpcode2(reqOpcode2),
        .reqOffset1(reqOffset1), .reqOffset2(reqOffset2),
        .reqRtValue1(reqRtValue1), .reqRtValue2(reqRtValue2),
        .stall(stall), .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata),
        .grantLoad(grantLoad), .grantSlot(grantSlot), .grantOpcode(grantOpcode),
        .grantOffset(grantOffset), .grantRtValue(grantRtValue)
    );

    data_ram ram (
        .clk(clk), .we(ramWe), .addr(ramAddr), .wdata(ramWdata), .rdata(ramRdata)
    );

    load_align loadAlign (
        .clk(clk), .rst(rst), .flush(flush), .grantLoad(grantLoad),
        .grantSlot(grantSlot), .grantOpcode(grantOpcode), .grantOffset(grantOffset),
        .grantRtValue(grantRtValue), .ramRdata(ramRdata),
        .loadValid(loadValid), .loadSlot(loadSlot), .loadData(loadData)
    );

endmodule

// File: bench/mem_stage_checker.sv
`timescale 1ns/100ps

module mem_stage_checker (
    input logic       clk,
    input logic       rst,
    input logic       stall,
    input logic       pending2,
    input logic       memReq1,
    input logic       memReq2,
    input logic [3:0] ramWe
);

    int assertFails = 0;

    // a stall hands the next cycle to slot 2
    assert property (@(posedge clk) disable iff (rst) stall |=> pending2)
        else begin
            assertFails++;
            $error("stall was not followed by a pending slot 2 grant");
        end

    assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
        else begin
            assertFails++;
            $error("stall lasted more than one cycle");
        end

    assert property (@(posedge clk) disable iff (rst) (!memReq1 && !memReq2) |-> ramWe == 4'b0000)
        else begin
            assertFails++;
            $error("RAM write enabled with no slot requesting");
        end

endmodule

// File: bench/mem_stage_tb.sv
`timescale 1ns/100ps
`include "mem_stage_consts.svh"

module mem_stage_tb;

    localparam int MAX_ROWS = 160;
    localparam logic [5:0] NOP_OP = 6'b000000;

    logic clk, rst, flush, stall, loadValid, loadSlot;
    logic storeErr1, loadErr1, storeErr2, loadErr2;
    logic [31:0] instr1, instr2, addr1, addr2, wdata1, wdata2, rtValue1, rtValue2, loadData;

    // tErr holds {loadErr2, storeErr2, loadErr1, storeErr1}
    logic [31:0] tInstr1 [MAX_ROWS];
    logic [31:0] tInstr2 [MAX_ROWS];
    logic [31:0] tAddr1 [MAX_ROWS];
    logic [31:0] tAddr2 [MAX_ROWS];
    logic [31:0] tWdata1 [MAX_ROWS];
    logic [31:0] tWdata2 [MAX_ROWS];
    logic [31:0] tRt1 [MAX_ROWS];
    logic [31:0] tRt2 [MAX_ROWS];
    logic        tFlush [MAX_ROWS];
    logic [3:0]  tErr [MAX_ROWS];
    int          rowCount = 0;

    logic [7:0]  memModel [0:1023];  // byte-addressed reference memory
    logic        pendValid, pendSlot;
    logic [31:0] pendData;
    int          errCount;
    integer      seed = 13;

    mem_stage dut (.*);

    bind mem_port_arbiter mem_stage_checker arbCheck (
        .clk(clk), .rst(rst), .stall(stall), .pending2(pending2),
        .memReq1(memReq1), .memReq2(memReq2), .ramWe(ramWe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic isMem(input logic [5:0] op);
        case (op)
            `OP_LB, `OP_LH, `OP_LWL, `OP_LW, `OP_LBU, `OP_LHU, `OP_LWR, `OP_LL: return 1'b1;
            `OP_SB, `OP_SH, `OP_SWL, `OP_SW, `OP_SWR, `OP_SC: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic isStore(input logic [5:0] op);
        return op inside {`OP_SB, `OP_SH, `OP_SWL, `OP_SW, `OP_SWR, `OP_SC};
    endfunction

    // {loadErr, storeErr}
    function automatic logic [1:0] alignErr(input logic [5:0] op, input logic [1:0] off);
        case (op)
            `OP_SW, `OP_SC: return {1'b0, off != 2'b00};
            `OP_SH: return {1'b0, off[0]};
            `OP_LW, `OP_LL: return {off != 2'b00, 1'b0};
            `OP_LH, `OP_LHU: return {off[0], 1'b0};
            default: return 2'b00;
        endcase
    endfunction

    function automatic logic [31:0] wordAt(input logic [31:0] a);
        int base;
        base = 4 * a[9:2];
        return {memModel[base+3], memModel[base+2], memModel[base+1], memModel[base]};
    endfunction

    function automatic logic [31:0] expectLoad(input logic [5:0] op, input logic [31:0] a,
                                               input logic [31:0] rt);
        logic [31:0] w;
        logic [31:0] res;
        int off;
        int half;
        off = a[1:0];
        half = off / 2;
        w = wordAt(a);
        res = rt;
        case (op)
            `OP_LW, `OP_LL: res = w;
            `OP_LH: res = {{16{w[16*half+15]}}, w[16*half +: 16]};
            `OP_LHU: res = {16'h0000, w[16*half +: 16]};
            `OP_LB: res = {{24{w[8*off+7]}}, w[8*off +: 8]};
            `OP_LBU: res = {24'h000000, w[8*off +: 8]};
            `OP_LWL: for (int k = 3 - off; k < 4; k++) res[8*k +: 8] = w[8*(k-3+off) +: 8];
            `OP_LWR: for (int k = 0; k <= 3 - off; k++) res[8*k +: 8] = w[8*(k+off) +: 8];
            default: res = 32'h0000_0000;
        endcase
        return res;
    endfunction

    task automatic applyStore(input logic [5:0] op, input logic [31:0] a, input logic [31:0] d);
        int base;
        int off;
        base = 4 * a[9:2];
        off = a[1:0];
        case (op)
            `OP_SW, `OP_SC: for (int k = 0; k < 4; k++) memModel[base+k] = d[8*k +: 8];
            `OP_SH: begin
                memModel[base+off] = d[7:0];
                memModel[base+off+1] = d[15:8];
            end
            `OP_SB: memModel[base+off] = d[7:0];
            `OP_SWL: for (int k = 0; k <= off; k++) memModel[base+k] = d[8*(k+3-off) +: 8];
            `OP_SWR: for (int k = off; k < 4; k++) memModel[base+k] = d[8*(k-off) +: 8];
            default: ;
        endcase
    endtask

    task automatic addRow(input logic [5:0] op1, input logic [31:0] a1,
                          input logic [5:0] op2, input logic [31:0] a2, input logic fl);
        tInstr1[rowCount] = {op1, 26'($random(seed))};
        tInstr2[rowCount] = {op2, 26'($random(seed))};
        tAddr1[rowCount] = a1;
        tAddr2[rowCount] = a2;
        tWdata1[rowCount] = $random(seed);
        tWdata2[rowCount] = $random(seed);
        tRt1[rowCount] = $random(seed);
        tRt2[rowCount] = $random(seed);
        tFlush[rowCount] = fl;
        tErr[rowCount] = {alignErr(op2, a2[1:0]), alignErr(op1, a1[1:0])};
        rowCount++;
    endtask

    task automatic buildTable();
        logic [5:0] badOp [8];
        int         badOff [8];
        badOp = '{`OP_SW, `OP_SW, `OP_SW, `OP_SH, `OP_SH, `OP_LW, `OP_LH, `OP_LHU};
        badOff = '{1, 2, 3, 1, 3, 2, 1, 3};
        for (int w = 0; w < 32; w += 2) addRow(`OP_SW, 4*w, `OP_SW, 4*w + 4, 1'b0);  // fill
        for (int off = 0; off < 4; off++) begin
            addRow(`OP_SB, 32'h40 + off, NOP_OP, 0, 1'b0);
            addRow(NOP_OP, 0, `OP_LW, 32'h40, 1'b0);
        end
        addRow(`OP_SW, 32'h44, NOP_OP, 0, 1'b0);
        addRow(`OP_LW, 32'h44, NOP_OP, 0, 1'b0);
        addRow(`OP_SC, 32'h48, NOP_OP, 0, 1'b0);
        addRow(`OP_LW, 32'h48, NOP_OP, 0, 1'b0);
        for (int off = 0; off < 4; off += 2) begin
            addRow(`OP_SH, 32'h4c + off, NOP_OP, 0, 1'b0);
            addRow(`OP_LW, 32'h4c, NOP_OP, 0, 1'b0);
        end
        for (int off = 0; off < 4; off++) begin
            addRow(`OP_SWL, 32'h50 + off, NOP_OP, 0, 1'b0);
            addRow(`OP_LW, 32'h50, NOP_OP, 0, 1'b0);
            addRow(NOP_OP, 0, `OP_SWR, 32'h54 + off, 1'b0);
            addRow(`OP_LW, 32'h54, NOP_OP, 0, 1'b0);
        end
        for (int off = 0; off < 4; off++) begin
            addRow(`OP_LB, 32'h40 + off, NOP_OP, 0, 1'b0);
            addRow(NOP_OP, 0, `OP_LBU, 32'h40 + off, 1'b0);
            addRow(`OP_LWL, 32'h50 + off, NOP_OP, 0, 1'b0);
            addRow(NOP_OP, 0, `OP_LWR, 32'h54 + off, 1'b0);
            if (off % 2 == 0) begin
                addRow(`OP_LH, 32'h4c + off, NOP_OP, 0, 1'b0);
                addRow(NOP_OP, 0, `OP_LHU, 32'h4c + off, 1'b0);
            end
        end
        for (int i = 0; i < 8; i++) begin
            addRow(badOp[i], 32'h60 + badOff[i], NOP_OP, 0, 1'b0);
            addRow(NOP_OP, 0, badOp[i], 32'h64 + badOff[i], 1'b0);
            addRow(`OP_LW, 32'h60, `OP_LW, 32'h64, 1'b0);
        end
        addRow(`OP_SW, 32'h70, `OP_LW, 32'h70, 1'b0);  // slot 1 store lands first
        addRow(`OP_LW, 32'h44, `OP_LW, 32'h54, 1'b0);
        addRow(`OP_SB, 32'h71, `OP_SB, 32'h71, 1'b0);
        addRow(`OP_LW, 32'h70, NOP_OP, 0, 1'b0);
        addRow(`OP_LWL, 32'h52, `OP_LWR, 32'h61, 1'b0);
        addRow(`OP_LW, 32'h48, NOP_OP, 0, 1'b0);
        addRow(`OP_LW, 32'h44, NOP_OP, 0, 1'b1);  // kills the load above and its own
        addRow(NOP_OP, 0, `OP_LW, 32'h48, 1'b0);
        addRow(NOP_OP, 0, NOP_OP, 0, 1'b0);
        addRow(NOP_OP, 0, NOP_OP, 0, 1'b0);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errCount++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // one clock cycle with row r on the inputs and the model stepped after it
    task automatic runCycle(input int r, input logic heldPass);
        logic [5:0]  op1, op2, gOp;
        logic        req1, req2, g1, g2, expStall, expValid;
        logic [31:0] gAddr, gData, gRt;
        op1 = tInstr1[r][31:26];
        op2 = tInstr2[r][31:26];
        @(posedge clk);
        #1;
        instr1 = tInstr1[r];
        instr2 = tInstr2[r];
        addr1 = tAddr1[r];
        addr2 = tAddr2[r];
        wdata1 = tWdata1[r];
        wdata2 = tWdata2[r];
        rtValue1 = tRt1[r];
        rtValue2 = tRt2[r];
        flush = tFlush[r];
        #2;
        req1 = isMem(op1) && (tErr[r][1:0] == 2'b00);
        req2 = isMem(op2) && (tErr[r][3:2] == 2'b00);
        // slot 1 first on a fresh row and slot 2 alone on the held row
        if (heldPass) begin
            expStall = 1'b0;
            g1 = 1'b0;
            g2 = req2;
        end else begin
            expStall = req1 && req2;
            g1 = req1;
            g2 = req2 && !req1;
        end
        expValid = pendValid && !tFlush[r];
        checkEq("stall", stall, expStall);
        checkEq("loadValid", loadValid, expValid);
        if (expValid) begin
            checkEq("loadSlot", loadSlot, pendSlot);
            checkEq("loadData", loadData, pendData);
        end
        checkEq("storeErr1", storeErr1, tErr[r][0]);
        checkEq("loadErr1", loadErr1, tErr[r][1]);
        checkEq("storeErr2", storeErr2, tErr[r][2]);
        checkEq("loadErr2", loadErr2, tErr[r][3]);
        pendValid = 1'b0;
        if (g1 || g2) begin
            gOp = g2 ? op2 : op1;
            gAddr = g2 ? tAddr2[r] : tAddr1[r];
            gData = g2 ? tWdata2[r] : tWdata1[r];
            gRt = g2 ? tRt2[r] : tRt1[r];
            if (isStore(gOp)) begin
                applyStore(gOp, gAddr, gData);
            end else begin
                pendValid = !tFlush[r];  // flush at grant clears M2
                pendSlot = g2;
                pendData = expectLoad(gOp, gAddr, gRt);
            end
        end
    endtask

    initial begin
        int   r;
        int   holdCycles;
        int   badRow;
        int   checkerFails;
        logic timedOut;
        rst = 1'b1;
        flush = 1'b0;
        instr1 = '0;
        instr2 = '0;
        addr1 = '0;
        addr2 = '0;
        wdata1 = '0;
        wdata2 = '0;
        rtValue1 = '0;
        rtValue2 = '0;
        errCount = 0;
        pendValid = 1'b0;
        pendSlot = 1'b0;
        pendData = '0;
        timedOut = 1'b0;
        badRow = 0;
        buildTable();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (r = 0; r < rowCount && !timedOut; r++) begin
            runCycle(r, 1'b0);
            holdCycles = 0;
            while (stall && !timedOut) begin  // hold the row while stalled
                if (holdCycles >= 2) begin
                    timedOut = 1'b1;
                    badRow = r;
                end else begin
                    holdCycles++;
                    runCycle(r, 1'b1);
                end
            end
        end
        checkerFails = dut.portArb.arbCheck.assertFails;
        if (timedOut) begin
            $display("timeout: stall stayed high while holding row %0d", badRow);
        end
        $display("checks failed: %0d, assertion failures: %0d", errCount, checkerFails);
        if (!timedOut && errCount == 0 && checkerFails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: mem_stage.f
+incdir+.
rtl/mem_pkg.sv
rtl/mem_access_unit.sv
rtl/mem_port_arbiter.sv
rtl/data_ram.sv
rtl/load_align.sv
rtl/mem_stage.sv
bench/mem_stage_checker.sv
bench/mem_stage_tb.sv
